// File: cfg/cfg_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_buffer (
	input  wire                                 I_sys_clk,
	input  wire                                 wr_en,
	input  wire  [nn_ctrl_pkg::BUF_ADDR_W-1:0]  wr_addr,
	input  wire  [nn_ctrl_pkg::CFG_WORD_W-1:0]  wr_data,
	input  wire  [nn_ctrl_pkg::BUF_ADDR_W-1:0]  rd_addr,
	output logic [nn_ctrl_pkg::CFG_WORD_W-1:0]  rd_data
);

	// one full transfer, layer n at addresses 4n..4n+3
	logic [nn_ctrl_pkg::CFG_WORD_W-1:0] mem [nn_ctrl_pkg::CFG_WORDS];

	always_ff @(posedge I_sys_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge I_sys_clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: cfg/cfg_intake.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_intake (
	input  wire                                 I_sys_clk,
	input  wire                                 I_sys_rst_n,
	input  wire  [nn_ctrl_pkg::CFG_WORD_W-1:0]  cfg_value,
	input  wire                                 cfg_valid,
	input  wire                                 rewind,
	output logic                                wr_en,
	output logic [nn_ctrl_pkg::BUF_ADDR_W-1:0]  wr_addr,
	output logic [nn_ctrl_pkg::CFG_WORD_W-1:0]  wr_data,
	output logic                                first_layer_ready
);

	// one extra bit so the count can sit at CFG_WORDS
	logic [nn_ctrl_pkg::BUF_ADDR_W:0] word_cnt;
	logic                             accept;

	assign accept = cfg_valid && (word_cnt < nn_ctrl_pkg::CFG_WORDS);

	always_ff @(posedge I_sys_clk) begin
		if (!I_sys_rst_n) begin
			word_cnt <= '0;
		end else if (rewind) begin
			word_cnt <= '0; // next task starts at address 0
		end else if (accept) begin
			word_cnt <= word_cnt + 1'b1;
		end
	end

	always_ff @(posedge I_sys_clk) begin
		if (!I_sys_rst_n) begin
			wr_en             <= 1'b0;
			first_layer_ready <= 1'b0;
		end else begin
			wr_en             <= accept;
			// fourth word landed, layer 0 complete in the buffer
			first_layer_ready <= wr_en && (wr_addr == nn_ctrl_pkg::WORDS_PER_LAYER - 1);
		end
	end

	// address and data for the buffer write
	always_ff @(posedge I_sys_clk) begin
		if (accept) begin
			wr_addr <= word_cnt[nn_ctrl_pkg::BUF_ADDR_W-1:0];
			wr_data <= cfg_value;
		end
	end

endmodule

`default_nettype wire

// File: cfg/layer_loader.sv
`timescale 1ns/1ps
`default_nettype none

module layer_loader (
	input  wire                                 I_sys_clk,
	input  wire                                 I_sys_rst_n,
	output logic [nn_ctrl_pkg::BUF_ADDR_W-1:0]  rd_addr,
	input  wire  [nn_ctrl_pkg::CFG_WORD_W-1:0]  rd_data,
	layer_cfg_if.loader                         link
);

	logic [nn_ctrl_pkg::BUF_ADDR_W-1:0]                base_addr; // first word of next layer
	logic [$clog2(nn_ctrl_pkg::WORDS_PER_LAYER):0]     step;
	logic                                              active;

	always_ff @(posedge I_sys_clk) begin
		if (!I_sys_rst_n) begin
			base_addr   <= '0;
		end else if (link.rewind) begin
			base_addr   <= '0;
		end else if (link.fetch) begin
			base_addr   <= base_addr +
				nn_ctrl_pkg::BUF_ADDR_W'(nn_ctrl_pkg::WORDS_PER_LAYER);
		end
	end

	// read sequencer
	// step 0 issues the first address, steps 1..4 see returned words
	always_ff @(posedge I_sys_clk) begin
		if (!I_sys_rst_n) begin
			active      <= 1'b0;
			step        <= '0;
			link.loaded <= 1'b0;
		end else begin
			link.loaded <= 1'b0;
			if (link.fetch) begin
				active <= 1'b1;
				step   <= '0;
			end else if (active) begin
				step <= step + 1'b1;
				if (step == nn_ctrl_pkg::WORDS_PER_LAYER) begin
					active      <= 1'b0;
					step        <= '0;
					link.loaded <= 1'b1; // last word captured this edge
				end
			end
		end
	end

	always_ff @(posedge I_sys_clk) begin
		if (link.fetch) begin
			rd_addr <= base_addr;
		end else if (active && (step < nn_ctrl_pkg::WORDS_PER_LAYER - 1)) begin
			rd_addr <= rd_addr + 1'b1;
		end
	end

	// first word read is the most significant
	always_ff @(posedge I_sys_clk) begin
		if (active && (step != 0)) begin
			link.cfg[nn_ctrl_pkg::LAYER_CFG_W - nn_ctrl_pkg::CFG_WORD_W * step
				+: nn_ctrl_pkg::CFG_WORD_W] <= rd_data;
		end
	end

endmodule

`default_nettype wire

// File: common/layer_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface layer_cfg_if;

	logic [nn_ctrl_pkg::LAYER_CFG_W-1:0] cfg;     // current layer
	logic                                loaded;  // cfg just refreshed
	logic                                fetch;   // request for the next layer
	logic                                rewind;  // back to layer 0

	modport loader (
		output cfg,
		output loaded,
		input  fetch,
		input  rewind
	);

	modport sequencer (
		input  cfg,
		input  loaded,
		output fetch,
		output rewind
	);

	modport dispatch (
		input  cfg
	);

endinterface

`default_nettype wire

// File: common/nn_ctrl_pkg.sv
`default_nettype none

package nn_ctrl_pkg;

	// word and buffer geometry
	localparam int CFG_WORD_W      = 128;
	localparam int LAYER_CFG_W     = 512;
	localparam int WORDS_PER_LAYER = 4;
	localparam int MAX_LAYERS      = 8;
	localparam int CFG_WORDS       = WORDS_PER_LAYER * MAX_LAYERS;
	localparam int BUF_ADDR_W      = 5;

	// fields of a layer configuration
	localparam int ALGO_SEL_LSB    = 1;
	localparam int ALGO_SEL_W      = 3;
	localparam int LAST_LAYER_BIT  = 9;
	localparam int RES_ADDR_LSB    = 64;  // 32-bit result address
	localparam int RES_LEN_LSB     = 96;  // 32-bit result length

	// DDR read request, {length, address}
	localparam int RD_DDR_CFG_W    = 64;

	localparam logic [ALGO_SEL_W-1:0] ALGO_CNN  = 3'd1;
	localparam logic [ALGO_SEL_W-1:0] ALGO_FC   = 3'd2;
	localparam logic [ALGO_SEL_W-1:0] ALGO_LSTM = 3'd3;

	// task sequencer states
	localparam logic [2:0] ST_IDLE        = 3'd0;
	localparam logic [2:0] ST_CONFIG      = 3'd1;
	localparam logic [2:0] ST_DATA_PREP   = 3'd2;
	localparam logic [2:0] ST_CAL         = 3'd3;
	localparam logic [2:0] ST_RESULT_READ = 3'd4;
	localparam logic [2:0] ST_LAYER_CFG   = 3'd5;

endpackage

`default_nettype wire

// File: logic/engine_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module engine_dispatch (
	input  wire                                   I_sys_clk,
	input  wire                                   I_sys_rst_n,
	layer_cfg_if.dispatch                         link,
	input  wire                                   cfg_send,
	input  wire                                   cal_start,
	input  wire                                   result_req,
	input  wire                                   cnn_cal_done,
	input  wire                                   fc_cal_done,
	input  wire                                   lstm_cal_done,
	output logic                                  engine_done,
	output logic                                  spmv_sel,
	output logic                                  mode_sel,
	output logic                                  fc_relu_en,
	output logic [nn_ctrl_pkg::LAYER_CFG_W-1:0]   cnn_cfg_value,
	output logic [nn_ctrl_pkg::LAYER_CFG_W-1:0]   fc_cfg_value,
	output logic [nn_ctrl_pkg::LAYER_CFG_W-1:0]   lstm_cfg_value,
	output logic                                  cnn_cfg_valid,
	output logic                                  fc_cfg_valid,
	output logic                                  lstm_cfg_valid,
	output logic                                  cnn_cal_start,
	output logic                                  fc_cal_start,
	output logic                                  lstm_cal_start,
	output logic [nn_ctrl_pkg::RD_DDR_CFG_W-1:0]  rd_ddr_cfg,
	output logic                                  rd_ddr_cfg_valid
);

	localparam int HALF_W = nn_ctrl_pkg::RD_DDR_CFG_W / 2;

	logic [nn_ctrl_pkg::ALGO_SEL_W-1:0] algo;
	logic                               last_layer;
	logic                               is_cnn;
	logic                               is_fc;
	logic                               is_lstm;

	assign algo       = link.cfg[nn_ctrl_pkg::ALGO_SEL_LSB +: nn_ctrl_pkg::ALGO_SEL_W];
	assign last_layer = link.cfg[nn_ctrl_pkg::LAST_LAYER_BIT];
	assign is_cnn     = (algo == nn_ctrl_pkg::ALGO_CNN);
	assign is_fc      = (algo == nn_ctrl_pkg::ALGO_FC);
	assign is_lstm    = (algo == nn_ctrl_pkg::ALGO_LSTM);

	// engine config, value held at zero outside its valid cycle
	always_ff @(posedge I_sys_clk) begin
		if (!I_sys_rst_n) begin
			cnn_cfg_valid  <= 1'b0;
			fc_cfg_valid   <= 1'b0;
			lstm_cfg_valid <= 1'b0;
			cnn_cfg_value  <= '0;
			fc_cfg_value   <= '0;
			lstm_cfg_value <= '0;
		end else begin
			cnn_cfg_valid  <= cfg_send && is_cnn;
			fc_cfg_valid   <= cfg_send && is_fc;
			lstm_cfg_valid <= cfg_send && is_lstm;
			cnn_cfg_value  <= (cfg_send && is_cnn) ? link.cfg : '0;
			fc_cfg_value   <= (cfg_send && is_fc) ? link.cfg : '0;
			lstm_cfg_value <= (cfg_send && is_lstm) ? link.cfg : '0;
		end
	end

	always_ff @(posedge I_sys_clk) begin
		if (!I_sys_rst_n) begin
			spmv_sel   <= 1'b0;
			mode_sel   <= 1'b0;
			fc_relu_en <= 1'b0;
		end else if (cfg_send) begin
			spmv_sel <= is_cnn ? 1'b1 : ((is_fc || is_lstm) ? 1'b0 : spmv_sel);
			if (is_fc || is_lstm) begin
				mode_sel <= is_fc; // CNN keeps the old mode
			end
			if (is_fc) begin
				fc_relu_en <= !last_layer; // no relu on the final FC layer
			end
		end
	end

	always_ff @(posedge I_sys_clk) begin
		if (!I_sys_rst_n) begin
			cnn_cal_start    <= 1'b0;
			fc_cal_start     <= 1'b0;
			lstm_cal_start   <= 1'b0;
			engine_done      <= 1'b0;
			rd_ddr_cfg_valid <= 1'b0;
			rd_ddr_cfg       <= '0;
		end else begin
			cnn_cal_start    <= cal_start && is_cnn;
			fc_cal_start     <= cal_start && is_fc;
			lstm_cal_start   <= cal_start && is_lstm;
			engine_done      <= cnn_cal_done || fc_cal_done || lstm_cal_done;
			rd_ddr_cfg_valid <= result_req;
			// length in the upper half, address in the lower
			rd_ddr_cfg       <= result_req ?
				{link.cfg[nn_ctrl_pkg::RES_LEN_LSB +: HALF_W],
				 link.cfg[nn_ctrl_pkg::RES_ADDR_LSB +: HALF_W]} : '0;
		end
	end

endmodule

`default_nettype wire

// File: logic/nn_main_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module nn_main_ctrl (
	input  wire                                   I_sys_clk,
	input  wire                                   I_sys_rst_n,
	input  wire  [nn_ctrl_pkg::CFG_WORD_W-1:0]    cfg_value,
	input  wire                                   cfg_valid,
	input  wire                                   mac_to_ddr_done,
	input  wire                                   ddr_to_mac_done,
	input  wire                                   cnn_cal_done,
	input  wire                                   fc_cal_done,
	input  wire                                   lstm_cal_done,
	output logic                                  spmv_sel,
	output logic                                  mode_sel,
	output logic                                  fc_relu_en,
	output logic [nn_ctrl_pkg::LAYER_CFG_W-1:0]   cnn_cfg_value,
	output logic [nn_ctrl_pkg::LAYER_CFG_W-1:0]   fc_cfg_value,
	output logic [nn_ctrl_pkg::LAYER_CFG_W-1:0]   lstm_cfg_value,
	output logic                                  cnn_cfg_valid,
	output logic                                  fc_cfg_valid,
	output logic                                  lstm_cfg_valid,
	output logic                                  cnn_cal_start,
	output logic                                  fc_cal_start,
	output logic                                  lstm_cal_start,
	output logic [nn_ctrl_pkg::RD_DDR_CFG_W-1:0]  rd_ddr_cfg,
	output logic                                  rd_ddr_cfg_valid
);

	logic                               wr_en;
	logic [nn_ctrl_pkg::BUF_ADDR_W-1:0] wr_addr;
	logic [nn_ctrl_pkg::CFG_WORD_W-1:0] wr_data;
	logic [nn_ctrl_pkg::BUF_ADDR_W-1:0] rd_addr;
	logic [nn_ctrl_pkg::CFG_WORD_W-1:0] rd_data;
	logic                               first_layer_ready;
	logic                               rewind;
	logic                               cfg_send;
	logic                               cal_start;
	logic                               result_req;
	logic                               engine_done;

	layer_cfg_if link ();

	cfg_intake u_cfg_intake (
		.I_sys_clk         (I_sys_clk),
		.I_sys_rst_n       (I_sys_rst_n),
		.cfg_value         (cfg_value),
		.cfg_valid         (cfg_valid),
		.rewind            (rewind),
		.wr_en             (wr_en),
		.wr_addr           (wr_addr),
		.wr_data           (wr_data),
		.first_layer_ready (first_layer_ready)
	);

	cfg_buffer u_cfg_buffer (
		.I_sys_clk (I_sys_clk),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	layer_loader u_layer_loader (
		.I_sys_clk   (I_sys_clk),
		.I_sys_rst_n (I_sys_rst_n),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.link        (link.loader)
	);

	task_sequencer u_task_sequencer (
		.I_sys_clk         (I_sys_clk),
		.I_sys_rst_n       (I_sys_rst_n),
		.cfg_valid         (cfg_valid),
		.first_layer_ready (first_layer_ready),
		.mac_to_ddr_done   (mac_to_ddr_done),
		.ddr_to_mac_done   (ddr_to_mac_done),
		.engine_done       (engine_done),
		.link              (link.sequencer),
		.cfg_send          (cfg_send),
		.cal_start         (cal_start),
		.result_req        (result_req),
		.rewind_out        (rewind)
	);

	engine_dispatch u_engine_dispatch (
		.I_sys_clk        (I_sys_clk),
		.I_sys_rst_n      (I_sys_rst_n),
		.link             (link.dispatch),
		.cfg_send         (cfg_send),
		.cal_start        (cal_start),
		.result_req       (result_req),
		.cnn_cal_done     (cnn_cal_done),
		.fc_cal_done      (fc_cal_done),
		.lstm_cal_done    (lstm_cal_done),
		.engine_done      (engine_done),
		.spmv_sel         (spmv_sel),
		.mode_sel         (mode_sel),
		.fc_relu_en       (fc_relu_en),
		.cnn_cfg_value    (cnn_cfg_value),
		.fc_cfg_value     (fc_cfg_value),
		.lstm_cfg_value   (lstm_cfg_value),
		.cnn_cfg_valid    (cnn_cfg_valid),
		.fc_cfg_valid     (fc_cfg_valid),
		.lstm_cfg_valid   (lstm_cfg_valid),
		.cnn_cal_start    (cnn_cal_start),
		.fc_cal_start     (fc_cal_start),
		.lstm_cal_start   (lstm_cal_start),
		.rd_ddr_cfg       (rd_ddr_cfg),
		.rd_ddr_cfg_valid (rd_ddr_cfg_valid)
	);

endmodule

`default_nettype wire

// File: logic/task_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module task_sequencer (
	input  wire          I_sys_clk,
	input  wire          I_sys_rst_n,
	input  wire          cfg_valid,
	input  wire          first_layer_ready,
	input  wire          mac_to_ddr_done,
	input  wire          ddr_to_mac_done,
	input  wire          engine_done,
	layer_cfg_if.sequencer link,
	output logic         cfg_send,
	output logic         cal_start,
	output logic         result_req,
	output logic         rewind_out
);

	logic [2:0] state;

	assign link.rewind = rewind_out;

	always_ff @(posedge I_sys_clk) begin
		if (!I_sys_rst_n) begin
			state      <= nn_ctrl_pkg::ST_IDLE;
			link.fetch <= 1'b0;
			cfg_send   <= 1'b0;
			cal_start  <= 1'b0;
			result_req <= 1'b0;
			rewind_out <= 1'b0;
		end else begin
			// every output here is a one-cycle pulse
			link.fetch <= 1'b0;
			cfg_send   <= 1'b0;
			cal_start  <= 1'b0;
			result_req <= 1'b0;
			rewind_out <= 1'b0;

			case (state)
				nn_ctrl_pkg::ST_IDLE: begin
					if (cfg_valid) begin
						state <= nn_ctrl_pkg::ST_CONFIG;
					end
				end
				nn_ctrl_pkg::ST_CONFIG: begin
					if (first_layer_ready) begin
						link.fetch <= 1'b1; // layer 0 is in the buffer
					end
					if (link.loaded) begin
						cfg_send <= 1'b1;
						state    <= nn_ctrl_pkg::ST_DATA_PREP;
					end
				end
				nn_ctrl_pkg::ST_DATA_PREP: begin
					// input data still moving into DDR
					if (mac_to_ddr_done) begin
						cal_start <= 1'b1;
						state     <= nn_ctrl_pkg::ST_CAL;
					end
				end
				nn_ctrl_pkg::ST_CAL: begin
					if (engine_done) begin
						if (link.cfg[nn_ctrl_pkg::LAST_LAYER_BIT]) begin
							result_req <= 1'b1;
							state      <= nn_ctrl_pkg::ST_RESULT_READ;
						end else begin
							link.fetch <= 1'b1;
							state      <= nn_ctrl_pkg::ST_LAYER_CFG;
						end
					end
				end
				nn_ctrl_pkg::ST_LAYER_CFG: begin
					// config goes out first, start follows one cycle later
					if (cfg_send) begin
						cal_start <= 1'b1;
						state     <= nn_ctrl_pkg::ST_CAL;
					end else if (link.loaded) begin
						cfg_send <= 1'b1;
					end
				end
				nn_ctrl_pkg::ST_RESULT_READ: begin
					if (ddr_to_mac_done) begin
						rewind_out <= 1'b1;
						state      <= nn_ctrl_pkg::ST_IDLE;
					end
				end
				default: begin
					state <= nn_ctrl_pkg::ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: tb.f
common/nn_ctrl_pkg.sv
common/layer_cfg_if.sv
cfg/cfg_intake.sv
cfg/cfg_buffer.sv
cfg/layer_loader.sv
logic/task_sequencer.sv
logic/engine_dispatch.sv
logic/nn_main_ctrl.sv
tb/tb_clk_gen.sv
tb/nn_main_ctrl_tb.sv

// File: tb/nn_main_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nn_main_ctrl_tb;

	localparam int N_TASKS   = 6;
	localparam int MAX_GAP   = 7;  // three random bits
	localparam int LAYER_CYC = 16; // fetch, load, dispatch and done latency
	localparam int CYC_LIMIT = 2 * (8 + N_TASKS * (nn_ctrl_pkg::CFG_WORDS
		+ nn_ctrl_pkg::MAX_LAYERS * (LAYER_CYC + 2 * MAX_GAP) + 2 * MAX_GAP + 8));
	localparam int DRIVE_DLY = 1;
	localparam int EV_CFG    = 0;
	localparam int EV_START  = 1;
	localparam int EV_RD     = 2;
	localparam int P_MAC     = 4; // 1..3 select the engine done inputs
	localparam int P_DDR     = 5;

	logic I_sys_clk, I_sys_rst_n;
	logic [nn_ctrl_pkg::CFG_WORD_W-1:0] cfg_value;
	logic cfg_valid, mac_to_ddr_done, ddr_to_mac_done;
	logic cnn_cal_done, fc_cal_done, lstm_cal_done;
	logic spmv_sel, mode_sel, fc_relu_en;
	logic [nn_ctrl_pkg::LAYER_CFG_W-1:0] cnn_cfg_value, fc_cfg_value, lstm_cfg_value;
	logic cnn_cfg_valid, fc_cfg_valid, lstm_cfg_valid;
	logic cnn_cal_start, fc_cal_start, lstm_cal_start;
	logic [nn_ctrl_pkg::RD_DDR_CFG_W-1:0] rd_ddr_cfg;
	logic rd_ddr_cfg_valid;

	logic [nn_ctrl_pkg::CFG_WORD_W-1:0] task_words [nn_ctrl_pkg::CFG_WORDS];
	int          task_n, cyc, pulse_cyc, errors, checks, layer_total;
	logic        words_done;
	logic        m_spmv, m_mode, m_relu; // select model
	logic [31:0] lfsr = 32'h66875ad6;

	tb_clk_gen u_tb_clk_gen (.I_sys_clk(I_sys_clk), .I_sys_rst_n(I_sys_rst_n));

	nn_main_ctrl u_nn_main_ctrl (.*);

	always @(posedge I_sys_clk) cyc <= cyc + 1;

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	// word k of a layer sits at bit 384 - 128k
	function automatic logic [nn_ctrl_pkg::LAYER_CFG_W-1:0] combine_layer(input int l);
		logic [nn_ctrl_pkg::LAYER_CFG_W-1:0] v;
		v = '0;
		for (int k = 0; k < nn_ctrl_pkg::WORDS_PER_LAYER; k++) begin
			v[nn_ctrl_pkg::LAYER_CFG_W - nn_ctrl_pkg::CFG_WORD_W * (k + 1)
				+: nn_ctrl_pkg::CFG_WORD_W] = task_words[nn_ctrl_pkg::WORDS_PER_LAYER * l + k];
		end
		return v;
	endfunction

	function automatic logic [2:0] events_now();
		return {rd_ddr_cfg_valid, cnn_cal_start | fc_cal_start | lstm_cal_start,
			cnn_cfg_valid | fc_cfg_valid | lstm_cfg_valid};
	endfunction

	task automatic compare_val(input string name, input logic [511:0] got,
		input logic [511:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH %s: got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic require(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("ERROR: %s", what);
		end
	endtask

	task automatic report_and_finish();
		$display("%0d layers, %0d checks, %0d errors", layer_total, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	task automatic set_line(input int sel, input logic v);
		case (sel)
			1: cnn_cal_done = v;
			2: fc_cal_done = v;
			3: lstm_cal_done = v;
			P_MAC: mac_to_ddr_done = v;
			default: ddr_to_mac_done = v;
		endcase
	endtask

	task automatic drive_pulse(input int sel);
		@(posedge I_sys_clk);
		#DRIVE_DLY;
		pulse_cyc = cyc;
		set_line(sel, 1'b1);
		@(posedge I_sys_clk);
		#DRIVE_DLY;
		set_line(sel, 1'b0);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge I_sys_clk);
			require(events_now() == 3'b000, "unexpected output pulse during a gap");
		end
	endtask

	task automatic wait_event(input int kind, input string what);
		logic [2:0] ev;
		ev = '0;
		while (!ev[kind]) begin
			@(negedge I_sys_clk);
			ev = events_now();
			require((ev & ~(3'b001 << kind)) == 3'b000,
				{"unexpected output pulse while waiting for ", what});
		end
	endtask

	task automatic build_task();
		logic [2:0] code;
		task_n = int'(rand_bits(3)) + 1;
		for (int w = 0; w < nn_ctrl_pkg::CFG_WORDS; w++) begin
			for (int p = 0; p < 4; p++) begin
				task_words[w][32*p +: 32] = rand_bits(32);
			end
		end
		for (int l = 0; l < task_n; l++) begin
			code = 3'(rand_bits(8) % 3 + 1);
			// both fields live in the last word of a layer
			task_words[4*l+3][nn_ctrl_pkg::ALGO_SEL_LSB +: nn_ctrl_pkg::ALGO_SEL_W] = code;
			task_words[4*l+3][nn_ctrl_pkg::LAST_LAYER_BIT] = (l == task_n - 1);
		end
	endtask

	task automatic send_words();
		for (int w = 0; w < nn_ctrl_pkg::CFG_WORDS; w++) begin
			@(posedge I_sys_clk);
			#DRIVE_DLY;
			cfg_valid = 1'b1;
			cfg_value = task_words[w];
		end
		@(posedge I_sys_clk);
		#DRIVE_DLY;
		cfg_valid  = 1'b0;
		cfg_value  = '0;
		words_done = 1'b1;
	endtask

	task automatic check_config(input logic [511:0] exp, input logic [2:0] code,
		input logic last);
		compare_val("cnn_cfg_valid", cnn_cfg_valid, code == nn_ctrl_pkg::ALGO_CNN);
		compare_val("fc_cfg_valid", fc_cfg_valid, code == nn_ctrl_pkg::ALGO_FC);
		compare_val("lstm_cfg_valid", lstm_cfg_valid, code == nn_ctrl_pkg::ALGO_LSTM);
		compare_val("cnn_cfg_value", cnn_cfg_value, (code == nn_ctrl_pkg::ALGO_CNN) ? exp : '0);
		compare_val("fc_cfg_value", fc_cfg_value, (code == nn_ctrl_pkg::ALGO_FC) ? exp : '0);
		compare_val("lstm_cfg_value", lstm_cfg_value,
			(code == nn_ctrl_pkg::ALGO_LSTM) ? exp : '0);
		if (code == nn_ctrl_pkg::ALGO_CNN) begin
			m_spmv = 1'b1; // mode left alone
		end else begin
			m_spmv = 1'b0;
			m_mode = (code == nn_ctrl_pkg::ALGO_FC);
			if (code == nn_ctrl_pkg::ALGO_FC) m_relu = !last;
		end
		compare_val("spmv_sel", spmv_sel, m_spmv);
		compare_val("mode_sel", mode_sel, m_mode);
		compare_val("fc_relu_en", fc_relu_en, m_relu);
	endtask

	// plays the host and the engines for one task
	task automatic serve_layers();
		logic [nn_ctrl_pkg::LAYER_CFG_W-1:0] exp;
		logic [2:0] code;
		int         cfg_cyc;
		for (int l = 0; l < task_n; l++) begin
			exp  = combine_layer(l);
			code = exp[nn_ctrl_pkg::ALGO_SEL_LSB +: nn_ctrl_pkg::ALGO_SEL_W];
			wait_event(EV_CFG, "a layer configuration");
			cfg_cyc = cyc;
			check_config(exp, code, exp[nn_ctrl_pkg::LAST_LAYER_BIT]);
			if (l == 0) begin
				while (!words_done) idle_cycles(1); // transfer must finish first
				idle_cycles(rand_bits(3));
				drive_pulse(P_MAC);
			end
			wait_event(EV_START, "an engine start");
			if (l == 0) begin
				compare_val("mac_to_ddr_done to start cycles", cyc - pulse_cyc, 2);
			end else begin
				compare_val("config to start cycles", cyc - cfg_cyc, 1);
			end
			compare_val("cnn_cal_start", cnn_cal_start, code == nn_ctrl_pkg::ALGO_CNN);
			compare_val("fc_cal_start", fc_cal_start, code == nn_ctrl_pkg::ALGO_FC);
			compare_val("lstm_cal_start", lstm_cal_start, code == nn_ctrl_pkg::ALGO_LSTM);
			idle_cycles(rand_bits(3));
			drive_pulse(int'(code));
			layer_total++;
		end
		wait_event(EV_RD, "the DDR read request");
		compare_val("rd_ddr_cfg", rd_ddr_cfg, {exp[nn_ctrl_pkg::RES_LEN_LSB +: 32],
			exp[nn_ctrl_pkg::RES_ADDR_LSB +: 32]});
		idle_cycles(rand_bits(3));
		drive_pulse(P_DDR);
		idle_cycles(2); // rewind settles before the next transfer
	endtask

	initial begin
		cfg_value       = '0;
		cfg_valid       = 1'b0;
		mac_to_ddr_done = 1'b0;
		ddr_to_mac_done = 1'b0;
		cnn_cal_done    = 1'b0;
		fc_cal_done     = 1'b0;
		lstm_cal_done   = 1'b0;
		{m_spmv, m_mode, m_relu} = 3'b000;
		{cyc, errors, checks, layer_total} = '0;
		@(posedge I_sys_rst_n);
		@(negedge I_sys_clk);
		compare_val("valid and start outputs after reset", {events_now(),
			cnn_cfg_valid, fc_cfg_valid, lstm_cfg_valid,
			cnn_cal_start, fc_cal_start, lstm_cal_start}, '0);
		compare_val("selects after reset", {spmv_sel, mode_sel, fc_relu_en}, '0);
		for (int t = 0; t < N_TASKS; t++) begin
			words_done = 1'b0;
			build_task();
			fork
				send_words();
				serve_layers();
			join
			$display("task %0d finished: %0d layers, %0d errors so far", t, task_n, errors);
		end
		report_and_finish();
	end

	initial begin
		wait (cyc >= CYC_LIMIT);
		errors++;
		$display("ERROR: timeout after %0d cycles, the DUT stopped responding", cyc);
		report_and_finish();
	end

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic I_sys_clk,
	output logic I_sys_rst_n
);

	initial begin
		I_sys_clk = 1'b0;
		forever #(PERIOD_NS / 2) I_sys_clk = ~I_sys_clk;
	end

	// release lands just after an edge, like the other inputs
	initial begin
		I_sys_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge I_sys_clk);
		#1;
		I_sys_rst_n = 1'b1;
	end

endmodule

`default_nettype wire
